/* xr_mem_top.f */
src/xr_map_pkg.sv
src/xr_bus_pkg.sv
src/xr_ram.sv
src/xr_regs.sv
src/xrmem_arb.sv
src/xr_mem_top.sv
sim/xr_mem_asserts.sv
sim/xr_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the XR memory testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f xr_mem_top.f --top-module xr_mem_tb -o xr_mem_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/xr_mem_sim; then
    echo "simulation returned a failing status"
    exit 1
fi

echo "simulation completed"
exit 0

/* sim/xr_mem_tb.sv */
`default_nettype none

module xr_mem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import xr_map_pkg::*;
    import xr_bus_pkg::*;

    localparam int ACK_WAIT_LIMIT = 40;

    logic                     clk;
    logic                     arst_n;
    xr_host_req_t             host_req;
    logic                     host_ack;
    xr_word_t                 host_rdata;
    xr_copp_req_t             copp_req;
    logic                     copp_ack;
    logic                     color_sel;
    logic [COLOR_AWIDTH-1:0]  color_a_addr;
    logic [COLOR_AWIDTH-1:0]  color_b_addr;
    xr_word_t                 color_a_data;
    xr_word_t                 color_b_data;
    logic                     tile_sel;
    logic [TILE_AWIDTH-1:0]   tile_addr;
    xr_word_t                 tile_data;
    logic                     prog_sel;
    logic [COPPER_AWIDTH-1:0] prog_addr;
    copp_word_t               prog_data;

    // shadow copies of the register file and every memory
    xr_word_t sh_regs    [2**REG_COUNT_LOG2];
    xr_word_t sh_color_a [2**COLOR_AWIDTH];
    xr_word_t sh_color_b [2**COLOR_AWIDTH];
    xr_word_t sh_tile1   [2**(TILE_AWIDTH-1)];
    xr_word_t sh_tile2   [2**TILE2_AWIDTH];
    xr_word_t sh_even    [2**COPPER_AWIDTH];
    xr_word_t sh_odd     [2**COPPER_AWIDTH];

    logic       check_host = 1'b0;
    logic [2:0] vid_q = '0;
    xr_word_t   exp_a;
    xr_word_t   exp_b;
    xr_word_t   exp_tile;
    copp_word_t exp_prog;

    xr_mem_top xr_mem_top_inst (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .host_req_i     (host_req),
        .host_ack_o     (host_ack),
        .host_rdata_o   (host_rdata),
        .copp_req_i     (copp_req),
        .copp_ack_o     (copp_ack),
        .color_rd_sel_i (color_sel),
        .color_a_addr_i (color_a_addr),
        .color_b_addr_i (color_b_addr),
        .color_a_data_o (color_a_data),
        .color_b_data_o (color_b_data),
        .tile_rd_sel_i  (tile_sel),
        .tile_addr_i    (tile_addr),
        .tile_data_o    (tile_data),
        .prog_rd_sel_i  (prog_sel),
        .prog_addr_i    (prog_addr),
        .prog_data_o    (prog_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    // host view of the XR address map
    function automatic xr_word_t expected_read(input xr_addr_t addr);
        if (!addr[15]) begin
            return sh_regs[addr[3:0]];
        end else if (addr[15:13] == XR_COLOR_BASE[15:13]) begin
            return addr[8] ? sh_color_b[addr[7:0]] : sh_color_a[addr[7:0]];
        end else if (addr[15:13] == XR_TILE_BASE[15:13]) begin
            return addr[11] ? sh_tile2[addr[9:0]] : sh_tile1[addr[10:0]];
        end else if (addr[15:13] == XR_COPPER_BASE[15:13]) begin
            return addr[0] ? sh_odd[addr[10:1]] : sh_even[addr[10:1]];
        end
        return 'x;
    endfunction

    function automatic void store_shadow(input xr_addr_t addr, input xr_word_t data);
        if (!addr[15]) begin
            sh_regs[addr[3:0]] = data;
        end else if (addr[15:13] == XR_COLOR_BASE[15:13] && addr[8]) begin
            sh_color_b[addr[7:0]] = data;
        end else if (addr[15:13] == XR_COLOR_BASE[15:13]) begin
            sh_color_a[addr[7:0]] = data;
        end else if (addr[15:13] == XR_TILE_BASE[15:13] && addr[11]) begin
            sh_tile2[addr[9:0]] = data;
        end else if (addr[15:13] == XR_TILE_BASE[15:13]) begin
            sh_tile1[addr[10:0]] = data;
        end else if (addr[15:13] == XR_COPPER_BASE[15:13] && addr[0]) begin
            sh_odd[addr[10:1]] = data;
        end else if (addr[15:13] == XR_COPPER_BASE[15:13]) begin
            sh_even[addr[10:1]] = data;
        end
    endfunction

    // holds the request until acknowledged, then one idle cycle
    task automatic host_access(input logic wr, input xr_addr_t addr, input xr_word_t data,
                               input logic check, output int cycles);
        host_req = '{sel: 1'b1, wr: wr, addr: addr, data: data};
        check_host = check & ~wr;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!host_ack && cycles < ACK_WAIT_LIMIT);
        assert (host_ack) else stop_run($sformatf(
            "timeout, host request to %h not acknowledged within %0d cycles", addr, cycles));
        if (wr) begin
            store_shadow(addr, data);
        end
        host_req.sel = 1'b0;
        @(posedge clk);
        #1;
        check_host = 1'b0;
    endtask

    // uncontested access, acknowledge one cycle after select
    task automatic access_now(input logic wr, input xr_addr_t addr, input xr_word_t data);
        int lat;
        host_access(wr, addr, data, 1'b1, lat);
        assert (lat == 1) else stop_run($sformatf(
            "** Error %0t ns: access to %h acknowledged after %0d cycles", $time, addr, lat));
    endtask

    task automatic copp_write(input xr_addr_t addr, input xr_word_t data, output int cycles);
        copp_req = '{sel: 1'b1, addr: addr, data: data};
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!copp_ack && cycles < ACK_WAIT_LIMIT);
        assert (copp_ack) else stop_run($sformatf(
            "timeout, copper write to %h not acknowledged within %0d cycles", addr, cycles));
        store_shadow(addr, data);
        copp_req.sel = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // video addresses stay inside the prefilled window
    task automatic drive_video(input logic on);
        color_sel = on;
        tile_sel = on;
        prog_sel = on;
        color_a_addr = 8'($urandom % 16);
        color_b_addr = 8'($urandom % 16);
        tile_addr = {1'b0, 11'($urandom % 16)};
        if ($urandom % 2 == 1) begin
            tile_addr[11:10] = {1'b1, 1'($urandom)};
        end
        prog_addr = 10'($urandom % 8);
    endtask

    // video expectations taken when the read is sampled
    always @(posedge clk) begin
        vid_q <= {color_sel, tile_sel, prog_sel};
        exp_a <= sh_color_a[color_a_addr];
        exp_b <= sh_color_b[color_b_addr];
        exp_tile <= tile_addr[11] ? sh_tile2[tile_addr[9:0]] : sh_tile1[tile_addr[10:0]];
        exp_prog <= {sh_even[prog_addr], sh_odd[prog_addr]};
    end

    always @(negedge clk) begin
        if (arst_n && host_ack && check_host) begin
            assert (host_rdata === expected_read(host_req.addr)) else stop_run($sformatf(
                "** Error %0t ns: host read of %h returned %h, expected %h", $time,
                host_req.addr, host_rdata, expected_read(host_req.addr)));
        end
        if (vid_q[2]) begin
            assert (color_a_data === exp_a && color_b_data === exp_b) else stop_run($sformatf(
                "** Error %0t ns: colour read %h/%h, expected %h/%h", $time,
                color_a_data, color_b_data, exp_a, exp_b));
        end
        if (vid_q[1]) begin
            assert (tile_data === exp_tile) else stop_run($sformatf(
                "** Error %0t ns: tile read %h, expected %h", $time, tile_data, exp_tile));
        end
        if (vid_q[0]) begin
            assert (prog_data === exp_prog) else stop_run($sformatf(
                "** Error %0t ns: copper fetch %h, expected %h", $time, prog_data, exp_prog));
        end
    end

    initial begin
        int       lat_h;
        int       lat_c;
        xr_addr_t a;
        void'($urandom(62559));
        arst_n = 1'b0;
        host_req = '0;
        copp_req = '0;
        drive_video(1'b0);
        for (int i = 0; i < 16; i++) begin
            sh_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        assert (!host_ack && !copp_ack) else stop_run("acknowledge high right after reset");

        // registers clear after reset, then aliased read back
        for (int i = 0; i < 16; i++) begin
            access_now(1'b0, 16'(i), '0);
        end
        for (int i = 0; i < 30; i++) begin
            a = 16'($urandom) & 16'h7FFF;
            access_now(1'b1, a, 16'($urandom));
            access_now(1'b0, a ^ (16'($urandom) & 16'h7FF0), '0);
        end

        // window used by the video reads
        for (int i = 0; i < 16; i++) begin
            access_now(1'b1, XR_COLOR_BASE | 16'(i), 16'($urandom));
            access_now(1'b1, XR_COLOR_BASE | 16'h0100 | 16'(i), 16'($urandom));
            access_now(1'b1, XR_TILE_BASE | 16'(i), 16'($urandom));
            access_now(1'b1, XR_TILE_BASE | 16'h0800 | 16'(i), 16'($urandom));
            access_now(1'b1, XR_COPPER_BASE | 16'(i), 16'($urandom));
        end
        for (int i = 0; i < 60; i++) begin
            a = {3'(4 + i % 3), 13'($urandom)};
            access_now(1'b1, a, 16'($urandom));
            access_now(1'b0, a, '0);
        end

        repeat (40) begin
            drive_video(1'b1);
            @(posedge clk);
            #1;
        end
        drive_video(1'b0);

        // copper wins the shared write path
        repeat (4) begin
            fork
                copp_write({3'b110, 13'($urandom)}, 16'($urandom), lat_c);
                host_access(1'b1, {1'b0, 15'($urandom)}, 16'($urandom), 1'b0, lat_h);
            join
            assert (lat_c < lat_h) else stop_run($sformatf(
                "** Error %0t ns: copper ack after %0d cycles, host after %0d", $time,
                lat_c, lat_h));
            access_now(1'b0, copp_req.addr, '0);
            access_now(1'b0, host_req.addr, '0);
        end

        // host read waits for the video select to drop
        fork
            begin
                repeat (8) begin
                    drive_video(1'b1);
                    @(posedge clk);
                    #1;
                end
                drive_video(1'b0);
            end
            host_access(1'b0, XR_COLOR_BASE | 16'h0105, '0, 1'b1, lat_h);
        join
        assert (lat_h > 8) else stop_run($sformatf(
            "** Error %0t ns: host read served during video select", $time));

        // forced acknowledge for unmapped and starved reads
        host_access(1'b0, 16'hE000 | 16'($urandom % 64), '0, 1'b0, lat_h);
        assert (lat_h <= ACK_TIMEOUT + 3) else stop_run($sformatf(
            "** Error %0t ns: unmapped read took %0d cycles", $time, lat_h));
        fork
            begin
                repeat (ACK_TIMEOUT + 6) begin
                    drive_video(1'b1);
                    @(posedge clk);
                    #1;
                end
                drive_video(1'b0);
            end
            host_access(1'b0, XR_TILE_BASE | 16'h0003, '0, 1'b0, lat_h);
        join
        assert (lat_h <= ACK_TIMEOUT + 3) else stop_run($sformatf(
            "** Error %0t ns: starved read took %0d cycles", $time, lat_h));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/xr_mem_asserts.sv */
`default_nettype none

module xr_mem_asserts (
    input wire logic clk,
    input wire logic arst_n_i,
    input wire logic host_ack_i,
    input wire logic copp_ack_i,
    input wire logic copp_sel_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // acknowledges are single-cycle pulses
    host_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        host_ack_i |=> !host_ack_i)
        else $error("host acknowledge high for two consecutive cycles");

    copp_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        copp_ack_i |=> !copp_ack_i)
        else $error("copper acknowledge high for two consecutive cycles");

    // copper ack only answers a request
    copp_ack_cause: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(copp_ack_i) |-> $past(copp_sel_i))
        else $error("copper acknowledge without a copper select");

    ack_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!host_ack_i && !copp_ack_i))
        else $error("acknowledge high during reset");

endmodule

bind xrmem_arb xr_mem_asserts xr_mem_asserts_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .host_ack_i (host_ack_o),
    .copp_ack_i (copp_ack_o),
    .copp_sel_i (copp_req_i.sel)
);

`default_nettype wire

/* src/xr_mem_top.sv */
`default_nettype none

module xr_mem_top (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,

    input  wire xr_bus_pkg::xr_host_req_t             host_req_i,
    output logic                                      host_ack_o,
    output xr_map_pkg::xr_word_t                      host_rdata_o,

    input  wire xr_bus_pkg::xr_copp_req_t             copp_req_i,
    output logic                                      copp_ack_o,

    input  wire logic                                 color_rd_sel_i,
    input  wire logic [xr_map_pkg::COLOR_AWIDTH-1:0]  color_a_addr_i,
    input  wire logic [xr_map_pkg::COLOR_AWIDTH-1:0]  color_b_addr_i,
    output xr_map_pkg::xr_word_t                      color_a_data_o,
    output xr_map_pkg::xr_word_t                      color_b_data_o,

    input  wire logic                                 tile_rd_sel_i,
    input  wire logic [xr_map_pkg::TILE_AWIDTH-1:0]   tile_addr_i,
    output xr_map_pkg::xr_word_t                      tile_data_o,

    input  wire logic                                 prog_rd_sel_i,
    input  wire logic [xr_map_pkg::COPPER_AWIDTH-1:0] prog_addr_i,
    output xr_map_pkg::copp_word_t                    prog_data_o
);

    import xr_map_pkg::*;

    // register bus between arbiter and register file
    logic     reg_wr;
    xr_addr_t reg_addr;
    xr_word_t reg_wdata;
    xr_word_t reg_rdata;

    xrmem_arb #(
        .COLOR_AWIDTH  (COLOR_AWIDTH),
        .TILE_AWIDTH   (TILE_AWIDTH),
        .TILE2_AWIDTH  (TILE2_AWIDTH),
        .COPPER_AWIDTH (COPPER_AWIDTH)
    ) xrmem_arb_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .host_req_i     (host_req_i),
        .host_ack_o     (host_ack_o),
        .host_rdata_o   (host_rdata_o),
        .copp_req_i     (copp_req_i),
        .copp_ack_o     (copp_ack_o),
        .reg_wr_o       (reg_wr),
        .reg_addr_o     (reg_addr),
        .reg_wdata_o    (reg_wdata),
        .reg_rdata_i    (reg_rdata),
        .color_rd_sel_i (color_rd_sel_i),
        .color_a_addr_i (color_a_addr_i),
        .color_b_addr_i (color_b_addr_i),
        .color_a_data_o (color_a_data_o),
        .color_b_data_o (color_b_data_o),
        .tile_rd_sel_i  (tile_rd_sel_i),
        .tile_addr_i    (tile_addr_i),
        .tile_data_o    (tile_data_o),
        .prog_rd_sel_i  (prog_rd_sel_i),
        .prog_addr_i    (prog_addr_i),
        .prog_data_o    (prog_data_o)
    );

    xr_regs #(
        .INDEX_WIDTH (REG_COUNT_LOG2)
    ) xr_regs_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (reg_wr),
        .addr_i   (reg_addr),
        .wdata_i  (reg_wdata),
        .rdata_o  (reg_rdata)
    );

endmodule

`default_nettype wire

/* src/xrmem_arb.sv */
`default_nettype none

module xrmem_arb #(
    parameter int COLOR_AWIDTH  = xr_map_pkg::COLOR_AWIDTH,
    parameter int TILE_AWIDTH   = xr_map_pkg::TILE_AWIDTH,
    parameter int TILE2_AWIDTH  = xr_map_pkg::TILE2_AWIDTH,
    parameter int COPPER_AWIDTH = xr_map_pkg::COPPER_AWIDTH
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,

    // host port, read and write
    input  wire xr_bus_pkg::xr_host_req_t host_req_i,
    output logic                          host_ack_o,
    output xr_map_pkg::xr_word_t          host_rdata_o,

    // copper port, write only
    input  wire xr_bus_pkg::xr_copp_req_t copp_req_i,
    output logic                          copp_ack_o,

    // register bus
    output logic                          reg_wr_o,
    output xr_map_pkg::xr_addr_t          reg_addr_o,
    output xr_map_pkg::xr_word_t          reg_wdata_o,
    input  wire xr_map_pkg::xr_word_t     reg_rdata_i,

    // video colour lookup, both banks
    input  wire logic                     color_rd_sel_i,
    input  wire logic [COLOR_AWIDTH-1:0]  color_a_addr_i,
    input  wire logic [COLOR_AWIDTH-1:0]  color_b_addr_i,
    output xr_map_pkg::xr_word_t          color_a_data_o,
    output xr_map_pkg::xr_word_t          color_b_data_o,

    // video tile read
    input  wire logic                     tile_rd_sel_i,
    input  wire logic [TILE_AWIDTH-1:0]   tile_addr_i,
    output xr_map_pkg::xr_word_t          tile_data_o,

    // copper program fetch
    input  wire logic                     prog_rd_sel_i,
    input  wire logic [COPPER_AWIDTH-1:0] prog_addr_i,
    output xr_map_pkg::copp_word_t        prog_data_o
);

    import xr_map_pkg::*;

    localparam int ACK_CNT_W = $clog2(ACK_TIMEOUT);

    typedef struct packed {
        logic regs;
        logic color;
        logic tile;
        logic copp;
    } region_sel_t;

    function automatic region_sel_t decode_region(input xr_addr_t addr);
        region_sel_t rgn;
        rgn.regs  = ~addr[15];
        rgn.color = (addr[15:13] == XR_COLOR_BASE[15:13]);
        rgn.tile  = (addr[15:13] == XR_TILE_BASE[15:13]);
        rgn.copp  = (addr[15:13] == XR_COPPER_BASE[15:13]);
        return rgn;
    endfunction

    region_sel_t            host_rgn;
    region_sel_t            wr_rgn;

    logic                   host_live;
    logic                   host_rd_req;
    logic                   host_wr_go;
    logic                   copp_go;
    logic                   wr_go;
    xr_addr_t               wr_addr;
    xr_word_t               wr_data;

    logic                   color_wr_en;
    logic                   tile_wr_en;
    logic                   prog_wr_en;

    logic                   reg_rd_ack;
    logic                   color_rd_ack;
    logic                   tile_rd_ack;
    logic                   prog_rd_ack;
    logic                   ack_timeout;

    logic                   color_rd_en;
    logic [COLOR_AWIDTH-1:0] color_a_addr;
    logic [COLOR_AWIDTH-1:0] color_b_addr;
    logic                   tile_rd_en;
    logic [TILE_AWIDTH-1:0] tile_addr;
    logic                   tile_part;
    logic                   tile_part_q;
    xr_word_t               tile1_q;
    xr_word_t               tile2_q;
    logic                   prog_rd_en;
    logic [COPPER_AWIDTH-1:0] prog_addr;

    xr_word_t               reg_rdata_q;
    logic [ACK_CNT_W-1:0]   ack_count;

    // a request whose ack is high is already done
    assign host_live   = host_req_i.sel & ~host_ack_o;
    assign host_rd_req = host_live & ~host_req_i.wr;
    assign host_rgn    = decode_region(host_req_i.addr);

    // shared write path, copper first
    assign copp_go    = copp_req_i.sel & ~copp_ack_o;
    assign host_wr_go = host_live & host_req_i.wr & ~copp_go;
    assign wr_go      = copp_go | host_wr_go;
    assign wr_addr    = copp_go ? copp_req_i.addr : host_req_i.addr;
    assign wr_data    = copp_go ? copp_req_i.data : host_req_i.data;
    assign wr_rgn     = decode_region(wr_addr);

    assign color_wr_en = wr_go & wr_rgn.color;
    assign tile_wr_en  = wr_go & wr_rgn.tile;
    assign prog_wr_en  = wr_go & wr_rgn.copp;

    // register bus carries host reads only when the copper is idle
    assign reg_wr_o    = wr_go & wr_rgn.regs;
    assign reg_addr_o  = wr_addr;
    assign reg_wdata_o = wr_data;
    assign reg_rd_ack  = host_rd_req & host_rgn.regs & ~copp_go;

    // video select owns the read port, host read waits
    assign color_rd_ack = host_rd_req & host_rgn.color & ~color_rd_sel_i;
    assign color_rd_en  = color_rd_sel_i | color_rd_ack;
    assign color_a_addr = color_rd_sel_i ? color_a_addr_i : host_req_i.addr[COLOR_AWIDTH-1:0];
    assign color_b_addr = color_rd_sel_i ? color_b_addr_i : host_req_i.addr[COLOR_AWIDTH-1:0];

    assign tile_rd_ack = host_rd_req & host_rgn.tile & ~tile_rd_sel_i;
    assign tile_rd_en  = tile_rd_sel_i | tile_rd_ack;
    assign tile_addr   = tile_rd_sel_i ? tile_addr_i : host_req_i.addr[TILE_AWIDTH-1:0];
    assign tile_part   = tile_addr[TILE_AWIDTH-1];

    // word address, bit 0 picks the half
    assign prog_rd_ack = host_rd_req & host_rgn.copp & ~prog_rd_sel_i;
    assign prog_rd_en  = prog_rd_sel_i | prog_rd_ack;
    assign prog_addr   = prog_rd_sel_i ? prog_addr_i : host_req_i.addr[COPPER_AWIDTH:1];

    // part of the sampled tile read, lines up with the ram output
    always_ff @(posedge clk) begin
        if (tile_rd_en) begin
            tile_part_q <= tile_part;
        end
    end

    assign tile_data_o = tile_part_q ? tile2_q : tile1_q;

    always_ff @(posedge clk) begin
        if (reg_rd_ack) begin
            reg_rdata_q <= reg_rdata_i;
        end
    end

    // host read result by region
    always_comb begin
        host_rdata_o = reg_rdata_q;
        if (host_rgn.color) begin
            host_rdata_o = host_req_i.addr[COLOR_AWIDTH] ? color_b_data_o : color_a_data_o;
        end else if (host_rgn.tile) begin
            host_rdata_o = host_req_i.addr[TILE_AWIDTH-1] ? tile2_q : tile1_q;
        end else if (host_rgn.copp) begin
            host_rdata_o = host_req_i.addr[0] ? prog_data_o[15:0] : prog_data_o[31:16];
        end
    end

    // forced ack for unmapped or starved requests
    assign ack_timeout = host_live & (ack_count == ACK_CNT_W'(ACK_TIMEOUT - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            host_ack_o <= 1'b0;
            copp_ack_o <= 1'b0;
            ack_count  <= '0;
        end else begin
            host_ack_o <= host_wr_go | reg_rd_ack | color_rd_ack | tile_rd_ack
                        | prog_rd_ack | ack_timeout;
            copp_ack_o <= copp_go;
            if (!host_live) begin
                ack_count <= '0;
            end else begin
                ack_count <= ack_count + 1'b1;
            end
        end
    end

    // colour bank A, bit 8 clear
    xr_ram #(
        .AWIDTH (COLOR_AWIDTH),
        .DWIDTH ($bits(xr_word_t))
    ) color_a_ram (
        .clk       (clk),
        .rd_en_i   (color_rd_en),
        .rd_addr_i (color_a_addr),
        .rd_data_o (color_a_data_o),
        .wr_en_i   (color_wr_en & ~wr_addr[COLOR_AWIDTH]),
        .wr_addr_i (wr_addr[COLOR_AWIDTH-1:0]),
        .wr_data_i (wr_data)
    );

    // colour bank B, bit 8 set
    xr_ram #(
        .AWIDTH (COLOR_AWIDTH),
        .DWIDTH ($bits(xr_word_t))
    ) color_b_ram (
        .clk       (clk),
        .rd_en_i   (color_rd_en),
        .rd_addr_i (color_b_addr),
        .rd_data_o (color_b_data_o),
        .wr_en_i   (color_wr_en & wr_addr[COLOR_AWIDTH]),
        .wr_addr_i (wr_addr[COLOR_AWIDTH-1:0]),
        .wr_data_i (wr_data)
    );

    // tile part one, lower half of the tile space
    xr_ram #(
        .AWIDTH (TILE_AWIDTH - 1),
        .DWIDTH ($bits(xr_word_t))
    ) tile1_ram (
        .clk       (clk),
        .rd_en_i   (tile_rd_en & ~tile_part),
        .rd_addr_i (tile_addr[TILE_AWIDTH-2:0]),
        .rd_data_o (tile1_q),
        .wr_en_i   (tile_wr_en & ~wr_addr[TILE_AWIDTH-1]),
        .wr_addr_i (wr_addr[TILE_AWIDTH-2:0]),
        .wr_data_i (wr_data)
    );

    // tile part two, smaller and aliased
    xr_ram #(
        .AWIDTH (TILE2_AWIDTH),
        .DWIDTH ($bits(xr_word_t))
    ) tile2_ram (
        .clk       (clk),
        .rd_en_i   (tile_rd_en & tile_part),
        .rd_addr_i (tile_addr[TILE2_AWIDTH-1:0]),
        .rd_data_o (tile2_q),
        .wr_en_i   (tile_wr_en & wr_addr[TILE_AWIDTH-1]),
        .wr_addr_i (wr_addr[TILE2_AWIDTH-1:0]),
        .wr_data_i (wr_data)
    );

    // copper even words
    xr_ram #(
        .AWIDTH (COPPER_AWIDTH),
        .DWIDTH ($bits(xr_word_t))
    ) prog_even_ram (
        .clk       (clk),
        .rd_en_i   (prog_rd_en),
        .rd_addr_i (prog_addr),
        .rd_data_o (prog_data_o[31:16]),
        .wr_en_i   (prog_wr_en & ~wr_addr[0]),
        .wr_addr_i (wr_addr[COPPER_AWIDTH:1]),
        .wr_data_i (wr_data)
    );

    // copper odd words
    xr_ram #(
        .AWIDTH (COPPER_AWIDTH),
        .DWIDTH ($bits(xr_word_t))
    ) prog_odd_ram (
        .clk       (clk),
        .rd_en_i   (prog_rd_en),
        .rd_addr_i (prog_addr),
        .rd_data_o (prog_data_o[15:0]),
        .wr_en_i   (prog_wr_en & wr_addr[0]),
        .wr_addr_i (wr_addr[COPPER_AWIDTH:1]),
        .wr_data_i (wr_data)
    );

endmodule

`default_nettype wire

/* src/xr_regs.sv */
`default_nettype none

module xr_regs #(
    parameter int INDEX_WIDTH = 4
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,

    input  wire logic                 wr_i,
    input  wire xr_map_pkg::xr_addr_t addr_i,
    input  wire xr_map_pkg::xr_word_t wdata_i,
    output xr_map_pkg::xr_word_t      rdata_o
);

    import xr_map_pkg::*;

    localparam int REG_COUNT = 2**INDEX_WIDTH;

    xr_word_t               regs [REG_COUNT];
    logic [INDEX_WIDTH-1:0] index;

    // only the low bits decode, upper bits alias
    assign index = addr_i[INDEX_WIDTH-1:0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i) begin
            regs[index] <= wdata_i;
        end
    end

    // combinational read on the same index
    assign rdata_o = regs[index];

endmodule

`default_nettype wire

/* src/xr_ram.sv */
`default_nettype none

module xr_ram #(
    parameter int AWIDTH = 8,
    parameter int DWIDTH = 16
) (
    input  wire logic              clk,

    input  wire logic              rd_en_i,
    input  wire logic [AWIDTH-1:0] rd_addr_i,
    output logic      [DWIDTH-1:0] rd_data_o,

    input  wire logic              wr_en_i,
    input  wire logic [AWIDTH-1:0] wr_addr_i,
    input  wire logic [DWIDTH-1:0] wr_data_i
);

    logic [DWIDTH-1:0] mem [2**AWIDTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // output holds while no read is enabled
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

/* src/xr_bus_pkg.sv */
`default_nettype none

package xr_bus_pkg;

    // host request, held until the acknowledge pulse
    typedef struct packed {
        logic                 sel;
        logic                 wr;
        xr_map_pkg::xr_addr_t addr;
        xr_map_pkg::xr_word_t data;
    } xr_host_req_t;

    // copper request, always a write
    typedef struct packed {
        logic                 sel;
        xr_map_pkg::xr_addr_t addr;
        xr_map_pkg::xr_word_t data;
    } xr_copp_req_t;

endpackage

`default_nettype wire

/* src/xr_map_pkg.sv */
`default_nettype none

package xr_map_pkg;

    // one XR bus address and one XR data word
    typedef logic [15:0] xr_addr_t;
    typedef logic [15:0] xr_word_t;

    // copper instruction, even half in the high word, odd half in the low word
    typedef logic [31:0] copp_word_t;

    // colour lookup, one bank
    localparam int COLOR_AWIDTH = 8;

    // full tile address, top bit picks the second tile part
    localparam int TILE_AWIDTH = 12;

    // second tile part
    localparam int TILE2_AWIDTH = 10;

    // one copper half
    localparam int COPPER_AWIDTH = 10;

    // region bases, decoded on bits 15..13
    // bit 15 clear is the register bus, 0xE000 has nothing behind it
    localparam xr_addr_t XR_COLOR_BASE  = 16'h8000;
    localparam xr_addr_t XR_TILE_BASE   = 16'hA000;
    localparam xr_addr_t XR_COPPER_BASE = 16'hC000;

    // host select cycles before a forced acknowledge
    localparam int ACK_TIMEOUT = 16;

    // register file index width
    localparam int REG_COUNT_LOG2 = 4;

endpackage

`default_nettype wire
